//--- hdl/npu_pkg.sv
package npu_pkg;

	////////////////////////////////////////
	// Widths and depths
	////////////////////////////////////////

	// Operand and result words
	localparam int DATA_W = 32;
	// Config command words
	localparam int CFG_W = 26;
	// Operands per neuron group
	localparam int N_IN = 4;
	// Bits to select one weight
	localparam int IDX_W = $clog2(N_IN);
	// Shift amount field width
	localparam int SHIFT_W = 5;
	// Accumulator width, room for the sum plus bias
	localparam int ACC_W = 40;

	// FIFO depths
	localparam int IN_DEPTH = 16;
	localparam int CFG_DEPTH = 8;
	localparam int OUT_DEPTH = 4;

	////////////////////////////////////////
	// Types
	////////////////////////////////////////

	typedef logic [DATA_W-1:0] word_t;

	// Signed 16-bit weight, also used for operands
	typedef logic signed [15:0] weight_t;

	// Config opcodes, bits 25..24 of a command
	typedef enum logic [1:0] {
		OP_WEIGHT = 2'd0,
		OP_BIAS   = 2'd1,
		OP_SHIFT  = 2'd2,
		OP_CLEAR  = 2'd3
	} cfg_op_t;

	// Config command layout, 26 bits MSB first
	typedef struct packed {
		cfg_op_t     op;
		logic [3:0]  idx;
		logic [3:0]  rsvd;
		weight_t     value;
	} cfg_word_t;

	// Largest positive result after saturation
	localparam word_t RES_MAX = word_t'({1'b0, {(DATA_W-1){1'b1}}});

endpackage

//--- hdl/npu_cfg_if.sv
`timescale 1ns/1ns

interface npu_cfg_if
	import npu_pkg::*;
();

	// Register values, held steady while a group runs
	weight_t weight [N_IN];
	weight_t bias;
	logic [SHIFT_W-1:0] shift;

	// Config FIFO still has commands to apply
	logic cfg_pending;

	// Neuron mid-group or holding a result
	logic busy;

	// Register block side
	modport regs (
		output weight,
		output bias,
		output shift,
		output cfg_pending,
		input  busy
	);

	// Neuron side
	modport neuron (
		input  weight,
		input  bias,
		input  shift,
		input  cfg_pending,
		output busy
	);

endinterface

//--- hdl/npu_fifo.sv
`timescale 1ns/1ns

module npu_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int DEPTH = 4
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     wr_en,
	input  payload_t wr_data,
	output logic     full,
	input  logic     rd_en,
	output payload_t rd_data,
	output logic     empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_nxt;
	logic do_wr;
	logic do_rd;

	// Flags block the side that cannot proceed
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	// Head word always visible
	assign rd_data = mem[rd_ptr];

	// Occupancy after this edge
	always_comb begin
		count_nxt = count;
		if (do_wr && !do_rd) begin
			count_nxt = count + 1'b1;
		end else if (do_rd && !do_wr) begin
			count_nxt = count - 1'b1;
		end
	end

	// Storage array
	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// Pointers, count and registered flags
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			empty  <= 1'b1;
			full   <= 1'b0;
		end else begin
			// Wrap at DEPTH, which need not be a power of two
			if (do_wr) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count_nxt;
			empty <= (count_nxt == '0);
			full  <= (count_nxt == CNT_W'(DEPTH));
		end
	end

endmodule

//--- hdl/npu_weight_regs.sv
`timescale 1ns/1ns

module npu_weight_regs
	import npu_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  cfg_word_t cfg_data,
	input  logic      cfg_empty,
	output logic      cfg_pop,
	npu_cfg_if.regs   cfg
);

	logic idx_ok;
	logic [IDX_W-1:0] idx_sel;

	////////////////////////////////////////
	// Pop control
	////////////////////////////////////////

	// Tell the neuron not to start a group yet
	assign cfg.cfg_pending = !cfg_empty;

	// Only touch registers between groups
	assign cfg_pop = !cfg_empty && !cfg.busy;

	////////////////////////////////////////
	// Command decode
	////////////////////////////////////////

	// Out of range indices are dropped
	assign idx_ok  = (cfg_data.idx < 4'(N_IN));
	assign idx_sel = cfg_data.idx[IDX_W-1:0];

	// Popped word takes effect on the same edge
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < N_IN; i++) begin
				cfg.weight[i] <= '0;
			end
			cfg.bias  <= '0;
			cfg.shift <= '0;
		end else if (cfg_pop) begin
			case (cfg_data.op)
				OP_WEIGHT: begin
					if (idx_ok) begin
						cfg.weight[idx_sel] <= cfg_data.value;
					end
				end
				OP_BIAS: begin
					cfg.bias <= cfg_data.value;
				end
				// Only the low bits matter for a 40-bit accumulator
				OP_SHIFT: begin
					cfg.shift <= cfg_data.value[SHIFT_W-1:0];
				end
				OP_CLEAR: begin
					for (int i = 0; i < N_IN; i++) begin
						cfg.weight[i] <= '0;
					end
					cfg.bias  <= '0;
					cfg.shift <= '0;
				end
			endcase
		end
	end

endmodule

//--- hdl/npu_neuron.sv
`timescale 1ns/1ns

module npu_neuron
	import npu_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  word_t    in_data,
	input  logic     in_empty,
	output logic     in_pop,
	output word_t    out_data,
	input  logic     out_full,
	output logic     out_push,
	npu_cfg_if.neuron cfg
);

	typedef enum logic {
		ST_ACC  = 1'b0,
		ST_HOLD = 1'b1
	} state_t;

	state_t state;
	logic [IDX_W-1:0] cnt;
	logic last;

	weight_t operand;
	logic signed [ACC_W-1:0] product;
	logic signed [ACC_W-1:0] bias_ext;
	logic signed [ACC_W-1:0] acc;
	logic signed [ACC_W-1:0] acc_base;
	logic signed [ACC_W-1:0] acc_sum;
	logic signed [ACC_W-1:0] acc_shr;
	word_t sat;
	word_t result;

	////////////////////////////////////////
	// Handshakes
	////////////////////////////////////////

	// First operand waits for pending config
	assign in_pop = (state == ST_ACC) && !in_empty && ((cnt != '0) || !cfg.cfg_pending);

	// Held result leaves when the output FIFO has room
	assign out_push = (state == ST_HOLD) && !out_full;
	assign out_data = result;

	// Freezes the register block
	assign cfg.busy = (state == ST_HOLD) || (cnt != '0);

	assign last = (cnt == IDX_W'(N_IN - 1));

	////////////////////////////////////////
	// Multiply-accumulate
	////////////////////////////////////////

	// Low half of the word is the signed operand
	assign operand = weight_t'(in_data[15:0]);

	// Both factors signed, so extension to ACC_W is signed
	assign product  = operand * cfg.weight[cnt];
	assign bias_ext = cfg.bias;

	// Group starts from the bias
	assign acc_base = (cnt == '0) ? bias_ext : acc;
	assign acc_sum  = acc_base + product;

	// Arithmetic shift keeps the sign
	assign acc_shr = acc_sum >>> cfg.shift;

	// ReLU then clamp to the positive word range
	always_comb begin
		if (acc_shr[ACC_W-1]) begin
			sat = '0;
		end else if (|acc_shr[ACC_W-2:DATA_W-1]) begin
			sat = RES_MAX;
		end else begin
			sat = acc_shr[DATA_W-1:0];
		end
	end

	// Datapath registers
	always_ff @(posedge clk) begin
		if (in_pop) begin
			acc <= acc_sum;
			if (last) begin
				result <= sat;
			end
		end
	end

	////////////////////////////////////////
	// Controller
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_ACC;
			cnt   <= '0;
		end else begin
			case (state)
				ST_ACC: begin
					if (in_pop) begin
						// Last operand finishes the group
						if (last) begin
							cnt   <= '0;
							state <= ST_HOLD;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end
				ST_HOLD: begin
					if (out_push) begin
						state <= ST_ACC;
					end
				end
				default: begin
					state <= ST_ACC;
				end
			endcase
		end
	end

endmodule

//--- hdl/npu.sv
`timescale 1ns/1ns

module npu
	import npu_pkg::*;
(
	input  logic      clk,
	input  logic      rst,

	// Operand input FIFO
	input  word_t     npu_input_data,
	input  logic      npu_input_fifo_write_enable,
	output logic      npu_input_fifo_full,

	// Config command FIFO
	input  cfg_word_t npu_config_data,
	input  logic      npu_config_fifo_write_enable,
	output logic      npu_config_fifo_full,

	// Result output FIFO
	input  logic      npu_output_fifo_read_enable,
	output word_t     npu_output_data,
	output logic      npu_output_fifo_empty
);

	// Input FIFO read side
	word_t in_data;
	logic in_empty;
	logic in_pop;

	// Config FIFO read side
	cfg_word_t cfg_data;
	logic cfg_empty;
	logic cfg_pop;

	// Output FIFO write side
	word_t out_data;
	logic out_full;
	logic out_push;

	// Register values toward the neuron
	npu_cfg_if cfg_bus ();

	////////////////////////////////////////
	// FIFOs
	////////////////////////////////////////

	npu_fifo #(
		.payload_t (word_t),
		.DEPTH     (IN_DEPTH)
	) in_fifo_i (
		.clk     (clk),
		.rst     (rst),
		.wr_en   (npu_input_fifo_write_enable),
		.wr_data (npu_input_data),
		.full    (npu_input_fifo_full),
		.rd_en   (in_pop),
		.rd_data (in_data),
		.empty   (in_empty)
	);

	npu_fifo #(
		.payload_t (cfg_word_t),
		.DEPTH     (CFG_DEPTH)
	) cfg_fifo_i (
		.clk     (clk),
		.rst     (rst),
		.wr_en   (npu_config_fifo_write_enable),
		.wr_data (npu_config_data),
		.full    (npu_config_fifo_full),
		.rd_en   (cfg_pop),
		.rd_data (cfg_data),
		.empty   (cfg_empty)
	);

	// Results in group order
	npu_fifo #(
		.payload_t (word_t),
		.DEPTH     (OUT_DEPTH)
	) out_fifo_i (
		.clk     (clk),
		.rst     (rst),
		.wr_en   (out_push),
		.wr_data (out_data),
		.full    (out_full),
		.rd_en   (npu_output_fifo_read_enable),
		.rd_data (npu_output_data),
		.empty   (npu_output_fifo_empty)
	);

	////////////////////////////////////////
	// Register block and neuron
	////////////////////////////////////////

	npu_weight_regs regs_i (
		.clk       (clk),
		.rst       (rst),
		.cfg_data  (cfg_data),
		.cfg_empty (cfg_empty),
		.cfg_pop   (cfg_pop),
		.cfg       (cfg_bus.regs)
	);

	npu_neuron neuron_i (
		.clk      (clk),
		.rst      (rst),
		.in_data  (in_data),
		.in_empty (in_empty),
		.in_pop   (in_pop),
		.out_data (out_data),
		.out_full (out_full),
		.out_push (out_push),
		.cfg      (cfg_bus.neuron)
	);

endmodule

//--- tests/npu_clk_gen.sv
`timescale 1ns/1ns

module npu_clk_gen #(
	parameter int PERIOD = 4,
	parameter int RST_CYCLES = 2
) (
	output logic clk,
	output logic rst
);

	// Free-running clock
	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Reset held over the first rising edges
	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

//--- tests/npu_tb.sv
`timescale 1ns/1ns

module npu_tb
	import npu_pkg::*;
();

	localparam int N_ROWS = 6;
	localparam int N_RAND = 20;
	localparam int MAX_CFG = 8;
	localparam int TIMEOUT = (N_ROWS + N_RAND) * 64 + 200;
	// Groups that fit: output FIFO, one held result, input FIFO
	localparam int GROUP_CAP = OUT_DEPTH + 1 + IN_DEPTH / N_IN;

	// One table row, operands listed from index N_IN-1 down to 0
	typedef struct packed {
		logic [3:0] n_cfg;
		cfg_word_t [MAX_CFG-1:0] cfg;
		word_t [N_IN-1:0] opnd;
		logic [3:0] n_groups;
		logic [3:0] stall;
		logic exp_full;
	} row_t;

	logic clk;
	logic rst;
	word_t in_data;
	logic in_we;
	logic in_full;
	cfg_word_t cfg_data;
	logic cfg_we;
	logic cfg_full;
	logic out_re;
	word_t out_data;
	logic out_empty;

	row_t rows [N_ROWS];
	string row_name [N_ROWS];

	// Reference register state
	weight_t m_weight [N_IN];
	weight_t m_bias;
	logic [SHIFT_W-1:0] m_shift;

	logic [31:0] lfsr;
	int err_count;
	int pass_count;
	int fail_count;
	int cycles = 0;

	npu_clk_gen #(
		.PERIOD     (4),
		.RST_CYCLES (2)
	) clk_gen_i (
		.clk (clk),
		.rst (rst)
	);

	npu npu_i (
		.clk                          (clk),
		.rst                          (rst),
		.npu_input_data               (in_data),
		.npu_input_fifo_write_enable  (in_we),
		.npu_input_fifo_full          (in_full),
		.npu_config_data              (cfg_data),
		.npu_config_fifo_write_enable (cfg_we),
		.npu_config_fifo_full         (cfg_full),
		.npu_output_fifo_read_enable  (out_re),
		.npu_output_data              (out_data),
		.npu_output_fifo_empty        (out_empty)
	);

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic cfg_word_t make_cmd(input cfg_op_t op, input logic [3:0] idx,
			input int value);
		cfg_word_t w;
		w.op = op;
		w.idx = idx;
		w.rsvd = '0;
		w.value = value[15:0];
		return w;
	endfunction

	function automatic void model_cfg(input cfg_word_t w);
		case (w.op)
			// Indices past the last weight are dropped
			OP_WEIGHT: begin
				if (int'(w.idx) < N_IN) begin
					m_weight[w.idx[IDX_W-1:0]] = w.value;
				end
			end
			OP_BIAS: m_bias = w.value;
			OP_SHIFT: m_shift = w.value[SHIFT_W-1:0];
			default: begin
				for (int i = 0; i < N_IN; i++) begin
					m_weight[i] = '0;
				end
				m_bias = '0;
				m_shift = '0;
			end
		endcase
	endfunction

	function automatic word_t model_result(input logic [N_IN-1:0][DATA_W-1:0] opnd);
		longint acc;
		acc = longint'(m_bias);
		for (int i = 0; i < N_IN; i++) begin
			acc += longint'(m_weight[i]) * longint'($signed(opnd[i][15:0]));
		end
		acc = acc >>> m_shift;
		// ReLU, then clamp at 2^31 - 1
		if (acc < 0) begin
			return '0;
		end
		if (acc > 64'sd2147483647) begin
			return 32'h7FFF_FFFF;
		end
		return acc[DATA_W-1:0];
	endfunction

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_bit()};
		end
		return v;
	endfunction

	////////////////////////////////////////
	// Bus tasks
	////////////////////////////////////////

	task automatic write_cfg(input cfg_word_t w);
		@(posedge clk);
		cfg_we <= 1'b1;
		cfg_data <= w;
		@(negedge clk);
		while (cfg_full) @(negedge clk);
	endtask

	// Full seen at the negedge decides the next edge
	task automatic write_operand(input word_t w, output logic taken);
		@(posedge clk);
		in_we <= 1'b1;
		in_data <= w;
		@(negedge clk);
		taken = !in_full;
	endtask

	task automatic release_writes();
		@(posedge clk);
		in_we <= 1'b0;
		cfg_we <= 1'b0;
	endtask

	task automatic read_result(output word_t w);
		@(negedge clk);
		while (out_empty) @(negedge clk);
		w = out_data;
		@(posedge clk);
		out_re <= 1'b1;
		@(posedge clk);
		out_re <= 1'b0;
	endtask

	// Stalled neuron holds the config FIFO, so words pile up until full
	task automatic fill_cfg(input cfg_word_t w, input string name);
		model_cfg(w);
		for (int k = 0; k < CFG_DEPTH; k++) begin
			@(posedge clk);
			cfg_we <= 1'b1;
			cfg_data <= w;
			@(negedge clk);
			check_value(32'(cfg_full), 32'd0, {name, " config full early"});
		end
		release_writes();
		@(negedge clk);
		check_value(32'(cfg_full), 32'd1, {name, " config full"});
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("ERR at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
			err_count++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (err_count == errs_before) begin
			pass_count++;
			$display("%s: ok", name);
		end else begin
			fail_count++;
			$display("%s: FAILED with %0d mismatches", name, err_count - errs_before);
		end
	endtask

	////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////

	function automatic void build_table();
		row_t row;
		row = '0;
		row.n_cfg = 4'd7;
		row.cfg[0] = make_cmd(OP_CLEAR, 4'd0, 0);
		row.cfg[1] = make_cmd(OP_WEIGHT, 4'd0, 3);
		row.cfg[2] = make_cmd(OP_WEIGHT, 4'd1, -2);
		row.cfg[3] = make_cmd(OP_WEIGHT, 4'd2, 5);
		row.cfg[4] = make_cmd(OP_WEIGHT, 4'd3, -7);
		row.cfg[5] = make_cmd(OP_BIAS, 4'd0, 100);
		row.cfg[6] = make_cmd(OP_SHIFT, 4'd0, 1);
		// Upper half of operand 1 must be ignored
		row.opnd = {32'd4, -32'sd3, 32'hABCD_0014, 32'd10};
		row.n_groups = 4'd1;
		rows[0] = row;
		row_name[0] = "weighted sum";
		row = '0;
		row.n_cfg = 4'd4;
		row.cfg[0] = make_cmd(OP_CLEAR, 4'd0, 0);
		row.cfg[1] = make_cmd(OP_WEIGHT, 4'd0, -1000);
		row.cfg[2] = make_cmd(OP_WEIGHT, 4'd1, 5);
		row.cfg[3] = make_cmd(OP_BIAS, 4'd0, -50);
		row.opnd = {32'd4, 32'd3, 32'd2, 32'd1000};
		row.n_groups = 4'd1;
		row.stall = 4'd1;
		rows[1] = row;
		row_name[1] = "relu";
		row = '0;
		row.n_cfg = 4'd5;
		row.cfg[0] = make_cmd(OP_CLEAR, 4'd0, 0);
		for (int i = 0; i < N_IN; i++) begin
			row.cfg[i+1] = make_cmd(OP_WEIGHT, 4'(i), 32767);
		end
		row.opnd = {32'd32767, 32'd32767, 32'd32767, 32'd32767};
		row.n_groups = 4'd1;
		row.stall = 4'd2;
		rows[2] = row;
		row_name[2] = "saturation";
		// Bias alone after a clear
		row = '0;
		row.n_cfg = 4'd3;
		row.cfg[0] = make_cmd(OP_CLEAR, 4'd0, 0);
		row.cfg[1] = make_cmd(OP_BIAS, 4'd0, 1234);
		row.cfg[2] = make_cmd(OP_SHIFT, 4'd0, 2);
		row.opnd = {32'd400, 32'd300, 32'd200, 32'd100};
		row.n_groups = 4'd1;
		row.stall = 4'd3;
		rows[3] = row;
		row_name[3] = "clear and bias";
		// Index 4 aliases weight 0 and index 9 weight 1 if decoded wrong
		row = '0;
		row.n_cfg = 4'd3;
		row.cfg[0] = make_cmd(OP_WEIGHT, 4'd1, 7);
		row.cfg[1] = make_cmd(OP_WEIGHT, 4'd4, 999);
		row.cfg[2] = make_cmd(OP_WEIGHT, 4'd9, -300);
		row.opnd = {32'd1, 32'd1, 32'd40, 32'd8};
		row.n_groups = 4'd1;
		rows[4] = row;
		row_name[4] = "weight index range";
		// More groups than the pipeline can hold, reader stalled
		row = '0;
		row.n_cfg = 4'd5;
		row.cfg[0] = make_cmd(OP_CLEAR, 4'd0, 0);
		for (int i = 0; i < N_IN; i++) begin
			row.cfg[i+1] = make_cmd(OP_WEIGHT, 4'(i), i + 1);
		end
		row.opnd = {32'd4, 32'd3, 32'd2, 32'd1};
		row.n_groups = 4'd10;
		row.stall = 4'd8;
		row.exp_full = 1'b1;
		rows[5] = row;
		row_name[5] = "back-pressure";
	endfunction

	////////////////////////////////////////
	// Test sequences
	////////////////////////////////////////

	task automatic run_row(input int r);
		row_t row;
		int accepted;
		int expect_acc;
		int errs_before;
		logic taken;
		logic full_seen;
		word_t got;
		logic [N_IN-1:0][DATA_W-1:0] opnd;
		row = rows[r];
		errs_before = err_count;
		// Config first, so it covers every group of the row
		for (int k = 0; k < int'(row.n_cfg); k++) begin
			write_cfg(row.cfg[k]);
			model_cfg(row.cfg[k]);
		end
		release_writes();
		accepted = 0;
		full_seen = 1'b0;
		// Stop at the first refused write
		for (int g = 0; g < int'(row.n_groups) && !full_seen; g++) begin
			for (int i = 0; i < N_IN && !full_seen; i++) begin
				write_operand(row.opnd[i] + word_t'(g), taken);
				if (taken) begin
					accepted++;
				end else begin
					full_seen = 1'b1;
				end
			end
		end
		release_writes();
		expect_acc = row.exp_full ? GROUP_CAP * N_IN : int'(row.n_groups) * N_IN;
		check_value(32'(full_seen), 32'(row.exp_full), {row_name[r], " input full"});
		check_value(accepted, expect_acc, {row_name[r], " operands accepted"});
		// Rewriting the last command leaves the queued results unchanged
		if (row.exp_full) begin
			fill_cfg(row.cfg[int'(row.n_cfg) - 1], row_name[r]);
		end
		repeat (row.stall) @(posedge clk);
		// Group g used operands offset by g
		for (int g = 0; g < accepted / N_IN; g++) begin
			for (int i = 0; i < N_IN; i++) begin
				opnd[i] = row.opnd[i] + word_t'(g);
			end
			read_result(got);
			check_value(got, model_result(opnd), $sformatf("%s group %0d", row_name[r], g));
		end
		@(negedge clk);
		check_value(32'(out_empty), 32'd1, {row_name[r], " output empty"});
		report_test(row_name[r], errs_before);
	endtask

	task automatic run_random();
		cfg_word_t cmd;
		logic [N_IN-1:0][DATA_W-1:0] opnd;
		logic taken;
		word_t got;
		int errs_before;
		errs_before = err_count;
		for (int v = 0; v < N_RAND; v++) begin
			for (int i = 0; i < N_IN; i++) begin
				cmd = make_cmd(OP_WEIGHT, 4'(i), int'(rand_bits(16)));
				write_cfg(cmd);
				model_cfg(cmd);
			end
			cmd = make_cmd(OP_BIAS, 4'd0, int'(rand_bits(16)));
			write_cfg(cmd);
			model_cfg(cmd);
			cmd = make_cmd(OP_SHIFT, 4'd0, int'(rand_bits(SHIFT_W)));
			write_cfg(cmd);
			model_cfg(cmd);
			release_writes();
			for (int i = 0; i < N_IN; i++) begin
				opnd[i] = rand_bits(DATA_W);
				write_operand(opnd[i], taken);
				check_value(32'(taken), 32'd1, $sformatf("random %0d operand write", v));
			end
			release_writes();
			read_result(got);
			check_value(got, model_result(opnd), $sformatf("random %0d result", v));
		end
		report_test("random", errs_before);
	endtask

	////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////

	initial begin
		in_data = '0;
		in_we = 1'b0;
		cfg_data = '0;
		cfg_we = 1'b0;
		out_re = 1'b0;
		lfsr = 32'h6d0f75ab;
		err_count = 0;
		pass_count = 0;
		fail_count = 0;
		// Matches the register reset values
		for (int i = 0; i < N_IN; i++) begin
			m_weight[i] = '0;
		end
		m_bias = '0;
		m_shift = '0;
		build_table();
		@(negedge rst);
		@(posedge clk);
		for (int r = 0; r < N_ROWS; r++) begin
			run_row(r);
		end
		run_random();
		$display("tests: %0d passed, %0d failed, %0d mismatches", pass_count, fail_count,
			err_count);
		if (fail_count == 0 && err_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("timeout: the tests did not finish within %0d cycles", TIMEOUT);
			$display("test failed");
			$finish;
		end
	end

endmodule

//--- list.f
hdl/npu_pkg.sv
hdl/npu_cfg_if.sv
hdl/npu_fifo.sv
hdl/npu_weight_regs.sv
hdl/npu_neuron.sv
hdl/npu.sv
tests/npu_clk_gen.sv
tests/npu_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = npu_tb
FILELIST  = list.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

# Build and run; the result is taken from the log
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
